//--- files.f
+incdir+tests
design/mm_pkg.sv
design/mm_ctrl_pkg.sv
design/mm_control.sv
design/mm_addr_gen.sv
design/tile_buffer.sv
design/mac_array.sv
design/result_writer.sv
design/mm_top.sv
tests/tb_mm_top.sv

//--- tests/tb_mm_cases.svh
`ifndef TB_MM_CASES_SVH
`define TB_MM_CASES_SVH

// Up to three sizes with the first in sizes[0] and zero ending the list
typedef struct packed {
    logic [2:0][7:0] sizes;
    logic            hold;
} case_t;

localparam int NUM_CASES = 6;

function automatic case_t make_case(input logic [7:0] s0, input logic [7:0] s1,
                                    input logic [7:0] s2, input logic hold);
    case_t tc;
    tc.sizes[0] = s0;
    tc.sizes[1] = s1;
    tc.sizes[2] = s2;
    tc.hold     = hold;
    return tc;
endfunction

function automatic case_t case_entry(input int idx);
    case_t tc;
    case (idx)
        0:       tc = make_case(8'd4, 8'd0, 8'd0, 1'b0);
        1:       tc = make_case(8'd8, 8'd0, 8'd0, 1'b0);
        2:       tc = make_case(8'd4, 8'd8, 8'd4, 1'b0);
        3:       tc = make_case(8'd0, 8'd0, 8'd0, 1'b0);
        // Start held high through the run and beyond
        4:       tc = make_case(8'd8, 8'd4, 8'd0, 1'b1);
        default: tc = make_case(8'd4, 8'd0, 8'd0, 1'b0);
    endcase
    return tc;
endfunction

// Galois form shifting right
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'hD0000001;
    end
    return n;
endfunction

function automatic logic [7:0] random_byte();
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < 8; i++) begin
        v          = {v[6:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

// C[r][c] of instruction inst with bases advanced by 4N per earlier instruction
function automatic mm_pkg::acc_t reference_product(input case_t tc, input int inst,
                                                   input int r, input int c);
    int            a_base;
    int            b_base;
    int            n;
    mm_pkg::acc_t  sum;
    mm_pkg::elem_t av;
    mm_pkg::elem_t bv;
    a_base = 0;
    b_base = 0;
    for (int k = 0; k < inst; k++) begin
        a_base += 4 * int'(tc.sizes[k]);
        b_base += 4 * int'(tc.sizes[k]);
    end
    n   = tc.sizes[inst];
    sum = '0;
    for (int k = 0; k < 4; k++) begin
        av  = a_mem[a_base + r * 4 + k];
        bv  = b_mem[b_base + k * n + c];
        sum = sum + mm_pkg::acc_t'(av) * mm_pkg::acc_t'(bv);
    end
    return sum;
endfunction

`endif

//--- tests/tb_mm_top.sv
`timescale 1ns/1ps

module tb_mm_top;

    localparam int MEM_DEPTH   = 256;
    localparam int HOLD_CYCLES = 20;

    logic                  clk;
    logic                  rst;
    logic                  i_start;
    mm_pkg::elem_t         i_inst_rdata;
    mm_pkg::elem_t         i_a_rdata;
    mm_pkg::elem_t         i_b_rdata;
    logic                  o_done;
    mm_ctrl_pkg::mem_req_t o_inst_req;
    mm_ctrl_pkg::mem_req_t o_a_req;
    mm_ctrl_pkg::mem_req_t o_b_req;
    mm_ctrl_pkg::res_wr_t  o_res_wr;

    mm_pkg::elem_t inst_mem [0:MEM_DEPTH-1];
    mm_pkg::elem_t a_mem    [0:MEM_DEPTH-1];
    mm_pkg::elem_t b_mem    [0:MEM_DEPTH-1];
    mm_pkg::acc_t  out_mem  [0:MEM_DEPTH-1];
    int            out_hits [0:MEM_DEPTH-1];

    mm_ctrl_pkg::mem_req_t inst_req_q;
    mm_ctrl_pkg::mem_req_t a_req_q;
    mm_ctrl_pkg::mem_req_t b_req_q;
    mm_ctrl_pkg::res_wr_t  wr_q;
    logic [31:0]           lfsr_state;
    int                    errors;
    int                    cycle_count;
    int                    cycle_limit;
    int                    inst_req_count;
    int                    a_req_count;
    int                    b_req_count;
    int                    write_count;

    `include "tb_mm_cases.svh"

    mm_top DUT (
        .clk          (clk),
        .rst          (rst),
        .i_start      (i_start),
        .i_inst_rdata (i_inst_rdata),
        .i_a_rdata    (i_a_rdata),
        .i_b_rdata    (i_b_rdata),
        .o_done       (o_done),
        .o_inst_req   (o_inst_req),
        .o_a_req      (o_a_req),
        .o_b_req      (o_b_req),
        .o_res_wr     (o_res_wr)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Fail at %0t ns: %s is %0h, expected %0h",
                                $time, name, got, expected));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic record_write(input mm_ctrl_pkg::res_wr_t wr);
        if ((^wr.addr === 1'bx) || (wr.addr >= MEM_DEPTH)) begin
            abort_run($sformatf("Result write to an address outside the output array: %0h",
                                wr.addr));
        end
        out_mem[wr.addr]  = wr.data;
        out_hits[wr.addr] = out_hits[wr.addr] + 1;
        write_count++;
    endtask

    // Memories answer one cycle after an enabled request
    always @(posedge clk) begin
        inst_req_q = o_inst_req;
        a_req_q    = o_a_req;
        b_req_q    = o_b_req;
        wr_q       = o_res_wr;
        if (!rst) begin
            inst_req_count += (inst_req_q.en === 1'b1);
            a_req_count    += (a_req_q.en === 1'b1);
            b_req_count    += (b_req_q.en === 1'b1);
            if (wr_q.valid === 1'b1) begin
                record_write(wr_q);
            end
        end
        #1;
        if (inst_req_q.en === 1'b1) begin
            i_inst_rdata = inst_mem[inst_req_q.addr];
        end
        if (a_req_q.en === 1'b1) begin
            i_a_rdata = a_mem[a_req_q.addr];
        end
        if (b_req_q.en === 1'b1) begin
            i_b_rdata = b_mem[b_req_q.addr];
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
            abort_run($sformatf("Timeout: the DUT did not finish within %0d cycles",
                                cycle_limit));
        end
    end

    function automatic int compute_limit();
        int    limit;
        int    blk;
        logic  stop;
        case_t tc;
        limit = 100;
        for (int i = 0; i < NUM_CASES; i++) begin
            tc   = case_entry(i);
            stop = 1'b0;
            for (int k = 0; k < 3; k++) begin
                if (!stop) begin
                    blk   = tc.sizes[k] / 4;
                    limit += 70 * blk * blk + 30;
                    stop  = (tc.sizes[k] == 0);
                end
            end
            // Terminator after a full list
            if (!stop) begin
                limit += 30;
            end
        end
        return limit;
    endfunction

    task automatic load_memories(input case_t tc);
        for (int addr = 0; addr < MEM_DEPTH; addr++) begin
            a_mem[addr]    = random_byte();
            b_mem[addr]    = random_byte();
            inst_mem[addr] = '0;
            out_mem[addr]  = '0;
            out_hits[addr] = 0;
        end
        for (int k = 0; k < 3; k++) begin
            inst_mem[k] = tc.sizes[k];
        end
        inst_req_count = 0;
        a_req_count    = 0;
        b_req_count    = 0;
        write_count    = 0;
    endtask

    task automatic check_idle();
        repeat (5) begin
            compare_value("o_done", o_done, 1);
            compare_value("o_inst_req.en", o_inst_req.en, 0);
            compare_value("o_a_req.en", o_a_req.en, 0);
            compare_value("o_b_req.en", o_b_req.en, 0);
            compare_value("o_res_wr.valid", o_res_wr.valid, 0);
            next_cycle();
        end
    endtask

    task automatic wait_done();
        while (o_done !== 1'b1) begin
            next_cycle();
        end
    endtask

    task automatic run_case(input case_t tc);
        int   n_inst;
        int   exp_writes;
        int   exp_tiles;
        int   n;
        int   o_base;
        int   addr;
        logic stop;
        load_memories(tc);
        n_inst     = 0;
        exp_writes = 0;
        exp_tiles  = 0;
        stop       = 1'b0;
        for (int k = 0; k < 3; k++) begin
            stop = stop | (tc.sizes[k] == 0);
            if (!stop) begin
                n          = tc.sizes[k];
                n_inst     = n_inst + 1;
                exp_writes = exp_writes + n * n;
                exp_tiles  = exp_tiles + (n / 4) * (n / 4);
            end
        end
        i_start = 1'b1;
        next_cycle();
        compare_value("o_done", o_done, 0);
        if (!tc.hold) begin
            i_start = 1'b0;
        end
        wait_done();
        if (tc.hold) begin
            // A held start must not launch a second run
            repeat (HOLD_CYCLES) begin
                next_cycle();
                compare_value("o_done", o_done, 1);
            end
            i_start = 1'b0;
        end
        compare_value("write_count", write_count, exp_writes);
        compare_value("inst_req_count", inst_req_count, n_inst + 1);
        compare_value("a_req_count", a_req_count, 16 * exp_tiles);
        compare_value("b_req_count", b_req_count, 16 * exp_tiles);
        o_base = 0;
        for (int k = 0; k < n_inst; k++) begin
            n = tc.sizes[k];
            for (int r = 0; r < n; r++) begin
                for (int c = 0; c < n; c++) begin
                    addr = o_base + r * n + c;
                    compare_value($sformatf("out_hits[%0d]", addr), out_hits[addr], 1);
                    compare_value($sformatf("out_mem[%0d]", addr), out_mem[addr],
                                  reference_product(tc, k, r, c));
                end
            end
            o_base = o_base + n * n;
        end
        repeat (2) begin
            next_cycle();
        end
    endtask

    initial begin
        rst            = 1'b1;
        i_start        = 1'b0;
        i_inst_rdata   = '0;
        i_a_rdata      = '0;
        i_b_rdata      = '0;
        errors         = 0;
        cycle_count    = 0;
        inst_req_count = 0;
        a_req_count    = 0;
        b_req_count    = 0;
        write_count    = 0;
        lfsr_state     = 32'he14ced20;
        cycle_limit    = compute_limit();
        repeat (3) begin
            next_cycle();
        end
        rst = 1'b0;
        check_idle();
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(case_entry(i));
        end
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- design/mm_top.sv
`timescale 1ns/1ps

module mm_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_start,
    input  mm_pkg::elem_t         i_inst_rdata,
    input  mm_pkg::elem_t         i_a_rdata,
    input  mm_pkg::elem_t         i_b_rdata,
    output logic                  o_done,
    output mm_ctrl_pkg::mem_req_t o_inst_req,
    output mm_ctrl_pkg::mem_req_t o_a_req,
    output mm_ctrl_pkg::mem_req_t o_b_req,
    output mm_ctrl_pkg::res_wr_t  o_res_wr
);

    mm_ctrl_pkg::job_t      job;
    mm_ctrl_pkg::tile_pos_t pos;
    logic                   a_rd;
    logic                   b_rd;
    mm_pkg::idx_t           rd_idx;
    logic                   feed;
    logic [1:0]             beat;
    logic                   a_loaded;
    logic                   b_loaded;
    mm_pkg::vec_t           a_slice;
    mm_pkg::vec_t           b_slice;
    logic                   tile_done;
    mm_pkg::tile_res_t      result;
    logic                   tile_written;
    mm_pkg::idx_t           wr_idx;
    mm_pkg::addr_t          c_addr;

    mm_control u_control (
        .clk            (clk),
        .rst            (rst),
        .i_start        (i_start),
        .i_inst_rdata   (i_inst_rdata),
        .i_a_loaded     (a_loaded),
        .i_b_loaded     (b_loaded),
        .i_tile_done    (tile_done),
        .i_tile_written (tile_written),
        .o_done         (o_done),
        .o_inst_req     (o_inst_req),
        .o_job          (job),
        .o_pos          (pos),
        .o_a_rd         (a_rd),
        .o_b_rd         (b_rd),
        .o_rd_idx       (rd_idx),
        .o_feed         (feed),
        .o_beat         (beat)
    );

    mm_addr_gen u_addr_gen (
        .clk      (clk),
        .rst      (rst),
        .i_job    (job),
        .i_pos    (pos),
        .i_a_rd   (a_rd),
        .i_b_rd   (b_rd),
        .i_rd_idx (rd_idx),
        .i_wr_idx (wr_idx),
        .o_a_req  (o_a_req),
        .o_b_req  (o_b_req),
        .o_c_addr (c_addr)
    );

    // A is stored transposed so each beat reads one column
    tile_buffer #(.TRANSPOSE(1'b1)) a_buf (
        .clk      (clk),
        .rst      (rst),
        .i_rd     (a_rd),
        .i_rd_idx (rd_idx),
        .i_rdata  (i_a_rdata),
        .i_beat   (beat),
        .o_slice  (a_slice),
        .o_loaded (a_loaded)
    );

    tile_buffer #(.TRANSPOSE(1'b0)) b_buf (
        .clk      (clk),
        .rst      (rst),
        .i_rd     (b_rd),
        .i_rd_idx (rd_idx),
        .i_rdata  (i_b_rdata),
        .i_beat   (beat),
        .o_slice  (b_slice),
        .o_loaded (b_loaded)
    );

    mac_array u_mac_array (
        .clk         (clk),
        .rst         (rst),
        .i_feed      (feed),
        .i_beat      (beat),
        .i_a_vec     (a_slice),
        .i_b_vec     (b_slice),
        .o_tile_done (tile_done),
        .o_result    (result)
    );

    result_writer u_result_writer (
        .clk            (clk),
        .rst            (rst),
        .i_tile_done    (tile_done),
        .i_result       (result),
        .i_c_addr       (c_addr),
        .o_wr_idx       (wr_idx),
        .o_res_wr       (o_res_wr),
        .o_tile_written (tile_written)
    );

endmodule

//--- design/result_writer.sv
`timescale 1ns/1ps

module result_writer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_tile_done,
    input  mm_pkg::tile_res_t    i_result,
    input  mm_pkg::addr_t        i_c_addr,
    output mm_pkg::idx_t         o_wr_idx,
    output mm_ctrl_pkg::res_wr_t o_res_wr,
    output logic                 o_tile_written
);

    logic                 active;
    logic                 issue;
    mm_pkg::idx_t         idx;
    mm_pkg::tile_res_t    tile_q;
    mm_ctrl_pkg::res_wr_t pend;
    logic                 pend_last;

    // Element 0 goes out in the done cycle, straight from the array
    assign issue    = active | i_tile_done;
    assign o_wr_idx = idx;

    always_ff @(posedge clk) begin
        if (i_tile_done) begin
            tile_q <= i_result;
        end
        pend.addr     <= i_c_addr;
        pend.data     <= active ? tile_q[idx] : i_result[idx];
        o_res_wr.addr <= pend.addr;
        o_res_wr.data <= pend.data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active         <= 1'b0;
            idx            <= '0;
            pend.valid     <= 1'b0;
            pend_last      <= 1'b0;
            o_res_wr.valid <= 1'b0;
            o_tile_written <= 1'b0;
        end else begin
            pend.valid     <= issue;
            pend_last      <= issue && (idx == 4'(mm_pkg::TILE_ELEMS - 1));
            o_res_wr.valid <= pend.valid;
            o_tile_written <= pend_last;
            if (issue) begin
                // Index wraps to 0 after the last element
                idx    <= idx + 4'd1;
                active <= (idx != 4'(mm_pkg::TILE_ELEMS - 1));
            end
        end
    end

endmodule

//--- design/mac_array.sv
`timescale 1ns/1ps

module mac_array (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_feed,
    input  logic [1:0]        i_beat,
    input  mm_pkg::vec_t      i_a_vec,
    input  mm_pkg::vec_t      i_b_vec,
    output logic              o_tile_done,
    output mm_pkg::tile_res_t o_result
);

    mm_pkg::vec_t      a_q;
    mm_pkg::vec_t      b_q;
    logic              feed_q;
    logic [1:0]        beat_q;
    mm_pkg::tile_res_t acc_q;

    assign o_result = acc_q;

    always_ff @(posedge clk) begin
        a_q    <= i_a_vec;
        b_q    <= i_b_vec;
        beat_q <= i_beat;
    end

    always_ff @(posedge clk) begin
        mm_pkg::elem_t                    a_e;
        mm_pkg::elem_t                    b_e;
        logic signed [2*mm_pkg::ELEM_W-1:0] prod;
        mm_pkg::acc_t                     base;
        if (feed_q) begin
            for (int i = 0; i < mm_pkg::TILE_DIM; i++) begin
                for (int j = 0; j < mm_pkg::TILE_DIM; j++) begin
                    a_e  = a_q[i];
                    b_e  = b_q[j];
                    prod = a_e * b_e;
                    // Beat 0 starts a new tile
                    base = (beat_q == 2'd0) ? '0 : acc_q[i*mm_pkg::TILE_DIM + j];
                    acc_q[i*mm_pkg::TILE_DIM + j] <= base + mm_pkg::acc_t'(prod);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            feed_q      <= 1'b0;
            o_tile_done <= 1'b0;
        end else begin
            feed_q      <= i_feed;
            o_tile_done <= feed_q && (beat_q == 2'd3);
        end
    end

endmodule

//--- design/tile_buffer.sv
`timescale 1ns/1ps

module tile_buffer #(
    parameter bit TRANSPOSE = 1'b0
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_rd,
    input  mm_pkg::idx_t  i_rd_idx,
    input  mm_pkg::elem_t i_rdata,
    input  logic [1:0]    i_beat,
    output mm_pkg::vec_t  o_slice,
    output logic          o_loaded
);

    // Strobe and index follow the address register and the memory
    logic         rd_d1;
    logic         rd_d2;
    mm_pkg::idx_t idx_d1;
    mm_pkg::idx_t idx_d2;
    logic [3:0]   cap_cnt;

    mm_pkg::vec_t store [0:mm_pkg::TILE_DIM-1];

    assign o_slice = store[i_beat];

    always_ff @(posedge clk) begin
        idx_d1 <= i_rd_idx;
        idx_d2 <= idx_d1;
        if (rd_d2) begin
            if (TRANSPOSE) begin
                store[idx_d2[1:0]][idx_d2[3:2]] <= i_rdata;
            end else begin
                store[idx_d2[3:2]][idx_d2[1:0]] <= i_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_d1    <= 1'b0;
            rd_d2    <= 1'b0;
            cap_cnt  <= '0;
            o_loaded <= 1'b0;
        end else begin
            rd_d1    <= i_rd;
            rd_d2    <= rd_d1;
            o_loaded <= rd_d2 && (cap_cnt == 4'(mm_pkg::TILE_ELEMS - 1));
            if (rd_d2) begin
                cap_cnt <= cap_cnt + 4'd1;
            end
        end
    end

endmodule

//--- design/mm_addr_gen.sv
`timescale 1ns/1ps

module mm_addr_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  mm_ctrl_pkg::job_t      i_job,
    input  mm_ctrl_pkg::tile_pos_t i_pos,
    input  logic                   i_a_rd,
    input  logic                   i_b_rd,
    input  mm_pkg::idx_t           i_rd_idx,
    input  mm_pkg::idx_t           i_wr_idx,
    output mm_ctrl_pkg::mem_req_t  o_a_req,
    output mm_ctrl_pkg::mem_req_t  o_b_req,
    output mm_pkg::addr_t          o_c_addr
);

    mm_pkg::addr_t n_words;
    mm_pkg::addr_t a_addr;
    mm_pkg::addr_t b_addr;
    mm_pkg::addr_t c_row;
    mm_pkg::addr_t c_col;

    assign n_words = mm_pkg::addr_t'(i_job.size);

    // {row_blk, row, col} is (row_blk*4 + row)*4 + col
    assign a_addr = i_job.a_base + mm_pkg::addr_t'({i_pos.row_blk, i_rd_idx});

    assign b_addr = i_job.b_base
                  + mm_pkg::addr_t'(i_rd_idx[3:2]) * n_words
                  + mm_pkg::addr_t'({i_pos.col_blk, i_rd_idx[1:0]});

    // Global row and column of the element being written
    assign c_row    = mm_pkg::addr_t'({i_pos.row_blk, i_wr_idx[3:2]});
    assign c_col    = mm_pkg::addr_t'({i_pos.col_blk, i_wr_idx[1:0]});
    assign o_c_addr = i_job.o_base + c_row * n_words + c_col;

    always_ff @(posedge clk) begin
        o_a_req.addr <= a_addr;
        o_b_req.addr <= b_addr;
        if (rst) begin
            o_a_req.en <= 1'b0;
            o_b_req.en <= 1'b0;
        end else begin
            o_a_req.en <= i_a_rd;
            o_b_req.en <= i_b_rd;
        end
    end

endmodule

//--- design/mm_control.sv
`timescale 1ns/1ps

module mm_control (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_start,
    input  mm_pkg::elem_t          i_inst_rdata,
    input  logic                   i_a_loaded,
    input  logic                   i_b_loaded,
    input  logic                   i_tile_done,
    input  logic                   i_tile_written,
    output logic                   o_done,
    output mm_ctrl_pkg::mem_req_t  o_inst_req,
    output mm_ctrl_pkg::job_t      o_job,
    output mm_ctrl_pkg::tile_pos_t o_pos,
    output logic                   o_a_rd,
    output logic                   o_b_rd,
    output mm_pkg::idx_t           o_rd_idx,
    output logic                   o_feed,
    output logic [1:0]             o_beat
);

    mm_ctrl_pkg::ctrl_state_t state;

    logic                           start_d;
    logic                           start_pulse;
    mm_pkg::addr_t                  inst_ptr;
    mm_pkg::addr_t                  n_words;
    logic [4:0]                     ld_cnt;
    logic                           ld_issue;
    logic [1:0]                     beat;
    logic [mm_ctrl_pkg::BLK_W-1:0]  blocks;

    assign start_pulse = i_start & ~start_d;
    assign n_words     = mm_pkg::addr_t'(o_job.size);
    assign blocks      = {2'b00, o_job.size[mm_pkg::ELEM_W-1:2]};

    // Sixteen strobes and then a hold until the buffer reports
    assign ld_issue = ~ld_cnt[4];
    assign o_a_rd   = (state == mm_ctrl_pkg::LOAD_A) && ld_issue;
    assign o_b_rd   = (state == mm_ctrl_pkg::LOAD_B) && ld_issue;
    assign o_rd_idx = ld_cnt[3:0];
    assign o_feed   = (state == mm_ctrl_pkg::FEED);
    assign o_beat   = beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_d <= 1'b0;
        end else begin
            start_d <= i_start;
        end
    end

    always_ff @(posedge clk) begin
        o_inst_req.addr <= inst_ptr;
        if (rst) begin
            state         <= mm_ctrl_pkg::IDLE;
            o_done        <= 1'b1;
            o_inst_req.en <= 1'b0;
            inst_ptr      <= '0;
            o_job         <= '0;
            o_pos         <= '0;
            ld_cnt        <= '0;
            beat          <= '0;
        end else begin
            o_inst_req.en <= 1'b0;
            case (state)
                mm_ctrl_pkg::IDLE, mm_ctrl_pkg::DONE: begin
                    if (start_pulse) begin
                        o_done       <= 1'b0;
                        inst_ptr     <= '0;
                        o_job.a_base <= '0;
                        o_job.b_base <= '0;
                        o_job.o_base <= '0;
                        state        <= mm_ctrl_pkg::FETCH;
                    end
                end
                mm_ctrl_pkg::FETCH: begin
                    o_inst_req.en <= 1'b1;
                    state         <= mm_ctrl_pkg::WAIT_INST;
                end
                mm_ctrl_pkg::WAIT_INST: begin
                    state <= mm_ctrl_pkg::CHECK;
                end
                mm_ctrl_pkg::CHECK: begin
                    // Instruction word is on the bus this cycle
                    o_job.size <= i_inst_rdata;
                    o_pos      <= '0;
                    ld_cnt     <= '0;
                    if (i_inst_rdata == '0) begin
                        o_done <= 1'b1;
                        state  <= mm_ctrl_pkg::DONE;
                    end else begin
                        state <= mm_ctrl_pkg::LOAD_A;
                    end
                end
                mm_ctrl_pkg::LOAD_A: begin
                    if (ld_issue) begin
                        ld_cnt <= ld_cnt + 5'd1;
                    end
                    if (i_a_loaded) begin
                        ld_cnt <= '0;
                        state  <= mm_ctrl_pkg::LOAD_B;
                    end
                end
                mm_ctrl_pkg::LOAD_B: begin
                    if (ld_issue) begin
                        ld_cnt <= ld_cnt + 5'd1;
                    end
                    if (i_b_loaded) begin
                        ld_cnt <= '0;
                        state  <= mm_ctrl_pkg::FEED;
                    end
                end
                mm_ctrl_pkg::FEED: begin
                    // Beat wraps back to 0 after the last one
                    beat <= beat + 2'd1;
                    if (beat == 2'd3) begin
                        state <= mm_ctrl_pkg::WAIT_TILE;
                    end
                end
                mm_ctrl_pkg::WAIT_TILE: begin
                    if (i_tile_done) begin
                        state <= mm_ctrl_pkg::WRITE;
                    end
                end
                mm_ctrl_pkg::WRITE: begin
                    if (i_tile_written) begin
                        state <= mm_ctrl_pkg::ADVANCE;
                    end
                end
                mm_ctrl_pkg::ADVANCE: begin
                    ld_cnt <= '0;
                    if (o_pos.col_blk + 8'd1 < blocks) begin
                        o_pos.col_blk <= o_pos.col_blk + 8'd1;
                        state         <= mm_ctrl_pkg::LOAD_A;
                    end else if (o_pos.row_blk + 8'd1 < blocks) begin
                        o_pos.col_blk <= '0;
                        o_pos.row_blk <= o_pos.row_blk + 8'd1;
                        state         <= mm_ctrl_pkg::LOAD_A;
                    end else begin
                        // Last tile moves on to the next instruction
                        o_pos        <= '0;
                        inst_ptr     <= inst_ptr + 16'd1;
                        o_job.a_base <= o_job.a_base + (n_words << 2);
                        o_job.b_base <= o_job.b_base + (n_words << 2);
                        o_job.o_base <= o_job.o_base + n_words * n_words;
                        state        <= mm_ctrl_pkg::FETCH;
                    end
                end
                default: begin
                    state <= mm_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

//--- design/mm_ctrl_pkg.sv
package mm_ctrl_pkg;

    localparam int BLK_W = 8;

    typedef enum logic [3:0] {
        IDLE,
        FETCH,
        WAIT_INST,
        CHECK,
        LOAD_A,
        LOAD_B,
        FEED,
        WAIT_TILE,
        WRITE,
        ADVANCE,
        DONE
    } ctrl_state_t;

    typedef struct packed {
        logic          en;
        mm_pkg::addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic          valid;
        mm_pkg::addr_t addr;
        mm_pkg::acc_t  data;
    } res_wr_t;

    // Size is unsigned and a multiple of 4
    typedef struct packed {
        logic [mm_pkg::ELEM_W-1:0] size;
        mm_pkg::addr_t             a_base;
        mm_pkg::addr_t             b_base;
        mm_pkg::addr_t             o_base;
    } job_t;

    typedef struct packed {
        logic [BLK_W-1:0] row_blk;
        logic [BLK_W-1:0] col_blk;
    } tile_pos_t;

endpackage

//--- design/mm_pkg.sv
package mm_pkg;

    // Arithmetic sizes
    localparam int TILE_DIM   = 4;
    localparam int TILE_ELEMS = TILE_DIM * TILE_DIM;
    localparam int ELEM_W     = 8;
    localparam int ACC_W      = 32;
    localparam int ADDR_W     = 16;

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic [ADDR_W-1:0]        addr_t;

    // One feed slice with element i at [i]
    typedef elem_t [TILE_DIM-1:0] vec_t;

    // Tile result in row-major order with element r*4+c at [r*4+c]
    typedef acc_t [TILE_ELEMS-1:0] tile_res_t;

    // Upper two bits row, lower two bits column
    typedef logic [3:0] idx_t;

endpackage
